/* rtl/ualink_pkg.sv */
/*
 * shared widths, opcodes and payload types for the UALink command endpoint
 * referenced by scoped name from every RTL file that needs them
 */
package ualink_pkg;

   localparam int data_w    = 64;               // stream and memory word
   localparam int addr_w    = 8;
   localparam int mem_depth = 1 << addr_w;      // 256 words

   // one write or read burst is 64 bytes
   localparam int burst_len  = 8;
   localparam int beat_cnt_w = 3;

   // opcode sits in header bits 63:48
   localparam logic [15:0] op_write = 16'h0245;
   localparam logic [15:0] op_read  = 16'h0145;

   localparam int in_fifo_depth_bits  = 4;      // 16 beats
   localparam int cmd_fifo_depth_bits = 2;      // 4 queued reads

   typedef logic [data_w-1:0] mem_data_t;
   typedef logic [addr_w-1:0] mem_addr_t;

   // one stream beat as it sits in the input FIFO
   typedef struct packed {
      mem_data_t data;
      logic      last;
   } beat_t;

endpackage

/* rtl/stream_fifo.sv */
/*
 * fall-through FIFO, head word visible on dout while valid is high
 * payload type is a parameter so the same block carries beats or addresses
 */
module stream_fifo #(
   parameter type payload_t  = logic,
   parameter int  depth_bits = 2
) (
   input  logic     axi_aclk,
   input  logic     axi_resetn,
   input  logic     push,
   input  payload_t din,
   output logic     full,
   input  logic     pop,
   output payload_t dout,
   output logic     valid
);

   payload_t mem [2**depth_bits];
   logic [depth_bits-1:0] wr_ptr;
   logic [depth_bits-1:0] rd_ptr;
   logic [depth_bits:0]   count;   // one extra bit to tell full from empty

   assign full  = count[depth_bits];
   assign valid = count != '0;
   assign dout  = mem[rd_ptr];

   always_ff @(posedge axi_aclk) begin
      if (push) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;   // pointers wrap with the buffer
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // the producer must watch full and the consumer must watch valid
   a_no_overflow: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      !(push && full));
   a_no_underflow: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      !(pop && !valid));

endmodule

/* rtl/cmd_parser.sv */
/*
 * command parser between the input FIFO and the two memory engines
 * decodes the header opcode, routes write data, queues reads and drops the rest
 */
module cmd_parser (
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,
   input  ualink_pkg::beat_t     in_beat,
   input  logic                  in_valid,
   output logic                  in_pop,
   output logic                  wr_start,
   output ualink_pkg::mem_addr_t wr_addr,
   input  logic                  wr_busy,
   output ualink_pkg::mem_data_t wr_data,
   output logic                  wr_valid,
   input  logic                  wr_ready,
   output logic                  rd_push,
   output ualink_pkg::mem_addr_t rd_addr,
   input  logic                  rd_full
);

   typedef enum logic [1:0] {st_header, st_wdata, st_discard} state_t;

   state_t state;
   state_t state_next;
   logic [ualink_pkg::beat_cnt_w-1:0] cnt;   // write data words taken so far
   logic [15:0] opcode;
   logic        is_write;
   logic        is_read;
   logic        last_word;

   assign opcode    = in_beat.data[ualink_pkg::data_w-1 -: 16];
   assign is_write  = opcode == ualink_pkg::op_write;
   assign is_read   = opcode == ualink_pkg::op_read;
   assign last_word = cnt == ualink_pkg::beat_cnt_w'(ualink_pkg::burst_len - 1);

   // start address lives in the low header byte
   assign wr_addr = in_beat.data[ualink_pkg::addr_w-1:0];
   assign rd_addr = in_beat.data[ualink_pkg::addr_w-1:0];
   assign wr_data = in_beat.data;

   always_comb begin
      state_next = state;
      in_pop     = 1'b0;
      wr_start   = 1'b0;
      wr_valid   = 1'b0;
      rd_push    = 1'b0;
      case (state)
         st_header: begin
            if (in_valid && is_write) begin
               if (!wr_busy) begin   // engine finished the previous burst
                  wr_start   = 1'b1;
                  in_pop     = 1'b1;
                  state_next = st_wdata;
               end
            end else if (in_valid && is_read) begin
               // hold the read until the last write has reached memory
               if (!wr_busy && !rd_full) begin
                  rd_push = 1'b1;
                  in_pop  = 1'b1;
                  if (!in_beat.last) state_next = st_discard;
               end
            end else if (in_valid) begin
               in_pop = 1'b1;   // unknown opcode
               if (!in_beat.last) state_next = st_discard;
            end
         end
         st_wdata: begin
            wr_valid = in_valid;
            in_pop   = in_valid && wr_ready;
            if (in_pop && last_word) state_next = st_header;
         end
         st_discard: begin
            in_pop = in_valid;   // drain up to tlast
            if (in_valid && in_beat.last) state_next = st_header;
         end
         default: state_next = st_header;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state <= st_header;
         cnt   <= '0;
      end else begin
         state <= state_next;
         if (state == st_wdata && in_pop) cnt <= cnt + 1'b1;   // wraps back to 0 after 8
      end
   end

   // write packets carry exactly burst_len data words after the header
   a_write_framing: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (state == st_wdata && in_pop) |-> (in_beat.last == last_word));

endmodule

/* rtl/mem_write_engine.sv */
/*
 * write engine, takes the memory through the arbiter for one eight-word burst
 * one word is written per accepted data beat, address counts up and wraps
 */
module mem_write_engine (
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,
   input  logic                  wr_start,
   input  ualink_pkg::mem_addr_t wr_addr,
   output logic                  wr_busy,
   input  ualink_pkg::mem_data_t wr_data,
   input  logic                  wr_valid,
   output logic                  wr_ready,
   output logic                  req,
   input  logic                  ack,
   output logic                  mem_we,
   output ualink_pkg::mem_addr_t mem_addr,
   output ualink_pkg::mem_data_t mem_wdata
);

   typedef enum logic [1:0] {st_idle, st_burst, st_release} state_t;

   state_t state;
   ualink_pkg::mem_addr_t addr;
   logic [ualink_pkg::beat_cnt_w-1:0] cnt;

   assign wr_busy   = state != st_idle;   // covers the release until ack drops
   assign wr_ready  = (state == st_burst) && ack;
   assign mem_we    = wr_valid && wr_ready;
   assign mem_addr  = addr;
   assign mem_wdata = wr_data;

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state <= st_idle;
         req   <= 1'b0;
         cnt   <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (wr_start) begin
                  addr  <= wr_addr;
                  req   <= 1'b1;
                  state <= st_burst;
               end
            end
            st_burst: begin
               if (mem_we) begin
                  addr <= addr + 1'b1;   // modulo 256
                  cnt  <= cnt + 1'b1;
                  if (cnt == ualink_pkg::beat_cnt_w'(ualink_pkg::burst_len - 1)) begin
                     req   <= 1'b0;   // last word written, let go
                     state <= st_release;
                  end
               end
            end
            st_release: begin
               if (!ack) state <= st_idle;   // four-phase, wait for ack low
            end
            default: state <= st_idle;
         endcase
      end
   end

endmodule

/* rtl/mem_read_engine.sv */
/*
 * read engine, pops a read command and streams eight words on the master port
 * keeps the memory grant for the whole burst, including while the sink stalls
 */
module mem_read_engine (
   input  logic                        axi_aclk,
   input  logic                        axi_resetn,
   input  ualink_pkg::mem_addr_t       cmd_addr,
   input  logic                        cmd_valid,
   output logic                        cmd_pop,
   output logic                        req,
   input  logic                        ack,
   output logic                        mem_en,
   output ualink_pkg::mem_addr_t       mem_addr,
   input  ualink_pkg::mem_data_t       mem_rdata,
   output logic [ualink_pkg::data_w-1:0] m_axis_tdata,
   output logic                        m_axis_tvalid,
   input  logic                        m_axis_tready,
   output logic                        m_axis_tlast
);

   typedef enum logic [2:0] {st_idle, st_wait, st_read, st_data, st_offer, st_release} state_t;

   state_t state;
   ualink_pkg::mem_addr_t addr;
   logic [ualink_pkg::beat_cnt_w-1:0] cnt;   // beat index within the burst
   logic last_beat;

   assign last_beat = cnt == ualink_pkg::beat_cnt_w'(ualink_pkg::burst_len - 1);
   assign cmd_pop   = (state == st_idle) && cmd_valid;
   assign mem_en    = state == st_read;
   assign mem_addr  = addr;

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state         <= st_idle;
         req           <= 1'b0;
         cnt           <= '0;
         m_axis_tvalid <= 1'b0;
         m_axis_tlast  <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (cmd_valid) begin
                  addr  <= cmd_addr;
                  req   <= 1'b1;
                  state <= st_wait;
               end
            end
            st_wait: if (ack) state <= st_read;
            st_read: state <= st_data;   // rdata lands next cycle
            st_data: begin
               m_axis_tdata  <= mem_rdata;
               m_axis_tlast  <= last_beat;
               m_axis_tvalid <= 1'b1;
               addr          <= addr + 1'b1;
               if (last_beat) req <= 1'b0;   // no more memory accesses
               state <= st_offer;
            end
            st_offer: begin
               if (m_axis_tready) begin
                  m_axis_tvalid <= 1'b0;
                  cnt           <= cnt + 1'b1;
                  state         <= m_axis_tlast ? st_release : st_read;
               end
            end
            st_release: if (!ack) state <= st_idle;
            default: state <= st_idle;
         endcase
      end
   end

   // a stalled beat stays put on the stream
   a_hold_beat: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && !m_axis_tready) |=> ($stable(m_axis_tdata) && $stable(m_axis_tlast)));

endmodule

/* rtl/mem_arbiter.sv */
/*
 * four-phase req/ack arbiter for the single memory port
 * alternates priority between the write and read engines, steers the owner
 */
module mem_arbiter (
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,
   input  logic                  wr_req,
   output logic                  wr_ack,
   input  logic                  wr_we,
   input  ualink_pkg::mem_addr_t wr_addr,
   input  ualink_pkg::mem_data_t wr_wdata,
   input  logic                  rd_req,
   output logic                  rd_ack,
   input  logic                  rd_en,
   input  ualink_pkg::mem_addr_t rd_addr,
   output logic                  ram_en,
   output logic                  ram_we,
   output ualink_pkg::mem_addr_t ram_addr,
   output ualink_pkg::mem_data_t ram_wdata
);

   logic last_rd;   // read engine held the memory last

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ack  <= 1'b0;
         rd_ack  <= 1'b0;
         last_rd <= 1'b0;
      end else if (wr_ack && !wr_req) begin
         wr_ack <= 1'b0;
      end else if (rd_ack && !rd_req) begin
         rd_ack <= 1'b0;
      end else if (!wr_ack && !rd_ack) begin
         // on a tie the engine that did not go last wins
         if (wr_req && (!rd_req || last_rd)) begin
            wr_ack  <= 1'b1;
            last_rd <= 1'b0;
         end else if (rd_req) begin
            rd_ack  <= 1'b1;
            last_rd <= 1'b1;
         end
      end
   end

   assign ram_en    = (wr_ack && wr_we) || (rd_ack && rd_en);
   assign ram_we    = wr_ack && wr_we;
   assign ram_addr  = wr_ack ? wr_addr : rd_addr;
   assign ram_wdata = wr_wdata;   // only written while the write engine owns it

   a_one_owner: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      !(wr_ack && rd_ack));
   a_wr_ack_needs_req: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      $rose(wr_ack) |-> wr_req);
   a_rd_ack_needs_req: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      $rose(rd_ack) |-> rd_req);

endmodule

/* rtl/mem_bank.sv */
/*
 * single-port 256 x 64 memory, read-first, registered read data
 * rdata shows the addressed word one cycle after en
 */
module mem_bank (
   input  logic                  axi_aclk,
   input  logic                  en,
   input  logic                  we,
   input  ualink_pkg::mem_addr_t addr,
   input  ualink_pkg::mem_data_t wdata,
   output ualink_pkg::mem_data_t rdata
);

   ualink_pkg::mem_data_t mem [ualink_pkg::mem_depth];

   always_ff @(posedge axi_aclk) begin
      if (en) begin
         if (we) begin
            mem[addr] <= wdata;
         end
         rdata <= mem[addr];   // old contents on a write cycle
      end
   end

endmodule

/* rtl/ualink_turbo.sv */
/*
 * top level of the UALink command endpoint on a 64-bit AXI stream
 * slave stream carries write and read commands, master stream the read data
 */
module ualink_turbo (
   input  logic                          axi_aclk,
   input  logic                          axi_resetn,
   input  logic [ualink_pkg::data_w-1:0] s_axis_tdata,
   input  logic                          s_axis_tvalid,
   output logic                          s_axis_tready,
   input  logic                          s_axis_tlast,
   output logic [ualink_pkg::data_w-1:0] m_axis_tdata,
   output logic                          m_axis_tvalid,
   input  logic                          m_axis_tready,
   output logic                          m_axis_tlast
);

   ualink_pkg::beat_t     in_din;
   ualink_pkg::beat_t     in_beat;
   logic                  in_full;
   logic                  in_valid;
   logic                  in_pop;
   logic                  wr_start;
   ualink_pkg::mem_addr_t wr_addr;
   logic                  wr_busy;
   ualink_pkg::mem_data_t wr_data;
   logic                  wr_valid;
   logic                  wr_ready;
   logic                  rd_push;
   ualink_pkg::mem_addr_t rd_addr;
   logic                  rd_full;
   ualink_pkg::mem_addr_t cmd_addr;
   logic                  cmd_valid;
   logic                  cmd_pop;
   logic                  wr_req, wr_ack, wr_we;
   ualink_pkg::mem_addr_t wr_mem_addr;
   ualink_pkg::mem_data_t wr_mem_wdata;
   logic                  rd_req, rd_ack, rd_en;
   ualink_pkg::mem_addr_t rd_mem_addr;
   logic                  ram_en, ram_we;
   ualink_pkg::mem_addr_t ram_addr;
   ualink_pkg::mem_data_t ram_wdata, ram_rdata;

   assign s_axis_tready = !in_full;
   assign in_din        = '{data: s_axis_tdata, last: s_axis_tlast};

   stream_fifo #(.payload_t(ualink_pkg::beat_t), .depth_bits(ualink_pkg::in_fifo_depth_bits))
   u_in_fifo (
      .axi_aclk(axi_aclk), .axi_resetn(axi_resetn),
      .push(s_axis_tvalid && s_axis_tready), .din(in_din), .full(in_full),
      .pop(in_pop), .dout(in_beat), .valid(in_valid));

   cmd_parser u_parser (
      .axi_aclk(axi_aclk), .axi_resetn(axi_resetn),
      .in_beat(in_beat), .in_valid(in_valid), .in_pop(in_pop),
      .wr_start(wr_start), .wr_addr(wr_addr), .wr_busy(wr_busy),
      .wr_data(wr_data), .wr_valid(wr_valid), .wr_ready(wr_ready),
      .rd_push(rd_push), .rd_addr(rd_addr), .rd_full(rd_full));

   // pending read start addresses
   stream_fifo #(.payload_t(ualink_pkg::mem_addr_t), .depth_bits(ualink_pkg::cmd_fifo_depth_bits))
   u_cmd_fifo (
      .axi_aclk(axi_aclk), .axi_resetn(axi_resetn),
      .push(rd_push), .din(rd_addr), .full(rd_full),
      .pop(cmd_pop), .dout(cmd_addr), .valid(cmd_valid));

   mem_write_engine u_wr_eng (
      .axi_aclk(axi_aclk), .axi_resetn(axi_resetn),
      .wr_start(wr_start), .wr_addr(wr_addr), .wr_busy(wr_busy),
      .wr_data(wr_data), .wr_valid(wr_valid), .wr_ready(wr_ready),
      .req(wr_req), .ack(wr_ack),
      .mem_we(wr_we), .mem_addr(wr_mem_addr), .mem_wdata(wr_mem_wdata));

   mem_read_engine u_rd_eng (
      .axi_aclk(axi_aclk), .axi_resetn(axi_resetn),
      .cmd_addr(cmd_addr), .cmd_valid(cmd_valid), .cmd_pop(cmd_pop),
      .req(rd_req), .ack(rd_ack),
      .mem_en(rd_en), .mem_addr(rd_mem_addr), .mem_rdata(ram_rdata),
      .m_axis_tdata(m_axis_tdata), .m_axis_tvalid(m_axis_tvalid),
      .m_axis_tready(m_axis_tready), .m_axis_tlast(m_axis_tlast));

   mem_arbiter u_arb (
      .axi_aclk(axi_aclk), .axi_resetn(axi_resetn),
      .wr_req(wr_req), .wr_ack(wr_ack), .wr_we(wr_we),
      .wr_addr(wr_mem_addr), .wr_wdata(wr_mem_wdata),
      .rd_req(rd_req), .rd_ack(rd_ack), .rd_en(rd_en), .rd_addr(rd_mem_addr),
      .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata));

   mem_bank u_mem (
      .axi_aclk(axi_aclk), .en(ram_en), .we(ram_we),
      .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata));

endmodule

/* testbench/tb_ualink_turbo.sv */
/*
 * testbench for ualink_turbo, sends write, read and unknown packets on the slave stream
 * a reference memory predicts every read response, checked beat by beat on the master stream
 */
module tb_ualink_turbo;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int burst       = 8;
   localparam int rand_rounds = 6;
   // header plus data per write, one beat per read, 5-beat unknown packet
   localparam int total_beats = 10 + 10 + 40 + 6 + rand_rounds * 12;
   localparam int cycle_limit = 20 * total_beats + 200;
   localparam logic [63:0] seed = 64'd65;
   localparam logic [15:0] op_write = 16'h0245;
   localparam logic [15:0] op_read  = 16'h0145;

   logic        axi_aclk;
   logic        axi_resetn;
   logic [63:0] s_axis_tdata;
   logic        s_axis_tvalid;
   logic        s_axis_tready;
   logic        s_axis_tlast;
   logic [63:0] m_axis_tdata;
   logic        m_axis_tvalid;
   logic        m_axis_tready;
   logic        m_axis_tlast;

   logic [63:0] ref_mem [256];
   logic [63:0] exp_q [$];       // expected response words in command order
   logic [63:0] data_rng;
   logic [31:0] rdy_rng;
   logic [63:0] exp_word;
   logic        exp_last;
   logic [2:0]  out_idx;         // beat index within a response
   logic [7:0]  rand_addr;
   logic        ready_random;
   int          beats_sent;
   int          out_beats;
   int          value_errs;
   int          proto_errs;
   int          cycles;
   int          beats_before;

   ualink_turbo dut0 (
      .axi_aclk(axi_aclk), .axi_resetn(axi_resetn),
      .s_axis_tdata(s_axis_tdata), .s_axis_tvalid(s_axis_tvalid),
      .s_axis_tready(s_axis_tready), .s_axis_tlast(s_axis_tlast),
      .m_axis_tdata(m_axis_tdata), .m_axis_tvalid(m_axis_tvalid),
      .m_axis_tready(m_axis_tready), .m_axis_tlast(m_axis_tlast));

   function automatic logic [63:0] xorshift64(input logic [63:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 7);
      x = x ^ (x << 17);
      return x;
   endfunction

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // opcode in bits 63:48, start address in the low byte
   function automatic logic [63:0] make_header(input logic [15:0] op, input logic [7:0] addr);
      return {op, 40'h0, addr};
   endfunction

   initial begin
      axi_aclk = 1'b0;
      forever #4 axi_aclk = ~axi_aclk;
   end

   // all tasks start and end 1 ns after a rising edge
   task automatic send_beat(input logic [63:0] data, input logic last);
      s_axis_tdata  = data;
      s_axis_tlast  = last;
      s_axis_tvalid = 1'b1;
      do @(posedge axi_aclk); while (!s_axis_tready);
      #1;
      s_axis_tvalid = 1'b0;
      beats_sent++;
   endtask

   task automatic send_write(input logic [7:0] addr);
      logic [63:0] word;
      logic [7:0]  a;
      a = addr;
      send_beat(make_header(op_write, addr), 1'b0);
      for (int i = 0; i < burst; i++) begin
         data_rng   = xorshift64(data_rng);
         word       = data_rng;
         ref_mem[a] = word;
         send_beat(word, i == burst - 1);
         a = a + 8'd1;   // wraps past 255
      end
   endtask

   task automatic send_read(input logic [7:0] addr);
      logic [7:0] a;
      a = addr;
      for (int i = 0; i < burst; i++) begin
         exp_q.push_back(ref_mem[a]);
         a = a + 8'd1;
      end
      send_beat(make_header(op_read, addr), 1'b1);
   endtask

   task automatic send_unknown(input int n_beats);
      send_beat(make_header(16'h0345, 8'h40), 1'b0);
      for (int i = 1; i < n_beats; i++) begin
         data_rng = xorshift64(data_rng);
         send_beat(data_rng, i == n_beats - 1);
      end
   endtask

   // a queued read could see a later write otherwise
   task automatic wait_drain();
      while (exp_q.size() != 0) begin
         @(posedge axi_aclk);
         #1;
      end
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge axi_aclk);
         #1;
      end
   endtask

   // sink ready, random only in the last phase
   initial begin
      forever begin
         @(posedge axi_aclk);
         #1;
         if (ready_random) begin
            rdy_rng       = xorshift32(rdy_rng);
            m_axis_tready = rdy_rng[0];
         end else begin
            m_axis_tready = 1'b1;
         end
      end
   end

   always @(posedge axi_aclk) begin
      if (axi_resetn && m_axis_tvalid && m_axis_tready) begin
         out_beats++;
         if (exp_q.size() == 0) begin
            proto_errs++;
            $display("output beat at %0t while no read response was expected", $time);
         end else begin
            exp_word = exp_q.pop_front();
            exp_last = out_idx == 3'(burst - 1);
            assert (m_axis_tdata === exp_word) else begin
               value_errs++;
               $display("ERROR t=%0t m_axis_tdata exp %h got %h", $time, exp_word, m_axis_tdata);
            end
            assert (m_axis_tlast === exp_last) else begin
               value_errs++;
               $display("ERROR t=%0t m_axis_tlast exp %b got %b", $time, exp_last, m_axis_tlast);
            end
            out_idx <= out_idx + 3'd1;
         end
      end
   end

   a_reset_idle: assert property (@(posedge axi_aclk)
      $rose(axi_resetn) |-> (!m_axis_tvalid && s_axis_tready) [*4])
      else begin
         proto_errs++;
         $display("stream handshakes not idle right after reset at %0t", $time);
      end

   a_out_held: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (m_axis_tvalid && !m_axis_tready)
         |=> (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast)))
      else begin
         proto_errs++;
         $display("stalled output beat changed or dropped at %0t", $time);
      end

   initial begin
      while (cycles < cycle_limit) begin
         @(posedge axi_aclk);
         cycles++;
      end
      $display("timeout after %0d cycles, %0d response words still expected",
               cycles, exp_q.size());
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      m_axis_tready = 1'b1;
      ready_random  = 1'b0;
      data_rng      = seed;
      rdy_rng       = 32'(seed);
      out_idx       = '0;
      rand_addr     = '0;
      beats_sent    = 0;
      out_beats     = 0;
      value_errs    = 0;
      proto_errs    = 0;
      cycles        = 0;
      repeat (2) @(posedge axi_aclk);
      #1;
      axi_resetn = 1'b1;
      idle(6);   // reset idle window

      send_write(8'h20);   // write then read back
      idle(4);
      send_read(8'h20);
      wait_drain();
      send_write(8'h20);   // read right behind a write
      send_read(8'h20);
      wait_drain();

      send_write(8'h40);
      send_write(8'h80);
      send_write(8'hfa);   // wraps to 0x01
      send_write(8'h10);
      send_read(8'h80);
      send_read(8'hfa);
      send_read(8'h10);
      send_read(8'h40);
      wait_drain();

      beats_before = out_beats;
      send_unknown(5);
      idle(30);
      assert (out_beats == beats_before) else begin
         proto_errs++;
         $display("unknown opcode packet produced output beats");
      end
      send_read(8'h40);
      wait_drain();

      @(posedge axi_aclk);
      ready_random = 1'b1;
      #1;
      for (int r = 0; r < rand_rounds; r++) begin
         wait_drain();
         data_rng  = xorshift64(data_rng);
         rand_addr = data_rng[7:0];   // read back the burst just written
         send_write(rand_addr);
         send_read(rand_addr);
         send_read(8'h40);
         send_read(8'hfa);
      end
      wait_drain();
      idle(10);

      $display("sent %0d beats, checked %0d output beats, %0d value errors, %0d protocol errors",
               beats_sent, out_beats, value_errs, proto_errs);
      if (value_errs == 0 && proto_errs == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* Bender.yml */
package:
  name: ualink_turbo

sources:
  # package first, everything else refers to it by scoped name
  - rtl/ualink_pkg.sv
  - rtl/stream_fifo.sv
  - rtl/cmd_parser.sv
  - rtl/mem_write_engine.sv
  - rtl/mem_read_engine.sv
  - rtl/mem_arbiter.sv
  - rtl/mem_bank.sv
  - rtl/ualink_turbo.sv

  - target: test
    files:
      - testbench/tb_ualink_turbo.sv

/* vlog.f */
rtl/ualink_pkg.sv
rtl/stream_fifo.sv
rtl/cmd_parser.sv
rtl/mem_write_engine.sv
rtl/mem_read_engine.sv
rtl/mem_arbiter.sv
rtl/mem_bank.sv
rtl/ualink_turbo.sv
testbench/tb_ualink_turbo.sv
